// File: src/fpmul_pkg.sv
`default_nettype none

/* fpmul shared definitions: IEEE-754 single-precision format constants
   and the enums for operand class and special-result opcode */

package fpmul_pkg;

  // ========================================
  // format constants
  // ========================================

  // full word width
  localparam int FP_WIDTH = 32;
  // exponent field width
  localparam int EXP_BITS = 8;
  // stored mantissa width, hidden bit not counted
  localparam int MAN_BITS = 23;
  // single precision bias
  localparam int EXP_BIAS = 127;

  // exponent field of infinity or NaN
  localparam logic [EXP_BITS-1:0] EXP_ALL_ONES = 8'd255;
  // quiet NaN returned for infinity times zero
  localparam logic [FP_WIDTH-1:0] DEFAULT_NAN = 32'hFFC0_0000;

  // ========================================
  // enums
  // ========================================

  // operand class, denormals fold into zero
  typedef enum logic [1:0] {
    CLASS_ZERO   = 2'b00,
    CLASS_NORMAL = 2'b01,
    CLASS_INF    = 2'b10,
    CLASS_NAN    = 2'b11
  } fp_class_t;

  // special-result opcode carried down the pipe
  typedef enum logic [2:0] {
    SPEC_NONE        = 3'd0,
    SPEC_ZERO        = 3'd1,
    SPEC_INF         = 3'd2,
    SPEC_NAN_A       = 3'd3,
    SPEC_NAN_B       = 3'd4,
    SPEC_NAN_DEFAULT = 3'd5
  } special_t;

endpackage

`default_nettype wire

// File: src/fpmul_unpack.sv
`timescale 1ns/1ps
`default_nettype none

/* fpmul stage 1: splits both operands into fields, classifies them
   and settles the special-case code before the datapath */

module fpmul_unpack
  import fpmul_pkg::*;
(
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    in_valid,
  input  wire [FP_WIDTH-1:0]     a,
  input  wire [FP_WIDTH-1:0]     b,
  output logic                   s1_valid,
  output logic                   s1_sign,
  output logic [EXP_BITS-1:0]    s1_exp_a,
  output logic [EXP_BITS-1:0]    s1_exp_b,
  output logic [MAN_BITS:0]      s1_man_a,
  output logic [MAN_BITS:0]      s1_man_b,
  output special_t               s1_special,
  output logic [FP_WIDTH-1:0]    s1_nan_a,
  output logic [FP_WIDTH-1:0]    s1_nan_b
);

  // exponent 0 covers denormals too, they are treated as zero
  function automatic fp_class_t classify(input logic [EXP_BITS-1:0] exp,
                                         input logic [MAN_BITS-1:0] man);
    fp_class_t cls;
    if (exp == '0) begin
      cls = CLASS_ZERO;
    end else if (exp != EXP_ALL_ONES) begin
      cls = CLASS_NORMAL;
    end else if (man != '0) begin
      cls = CLASS_NAN;
    end else begin
      cls = CLASS_INF;
    end
    return cls;
  endfunction

  fp_class_t cls_a, cls_b;
  special_t  special;

  assign cls_a = classify(a[FP_WIDTH-2 -: EXP_BITS], a[MAN_BITS-1:0]);
  assign cls_b = classify(b[FP_WIDTH-2 -: EXP_BITS], b[MAN_BITS-1:0]);

  // special priority, A-side NaN wins over B-side NaN
  always_comb begin
    if (cls_a == CLASS_NAN) begin
      special = SPEC_NAN_A;
    end else if (cls_b == CLASS_NAN) begin
      special = SPEC_NAN_B;
    end else if ((cls_a == CLASS_INF && cls_b == CLASS_ZERO) ||
                 (cls_a == CLASS_ZERO && cls_b == CLASS_INF)) begin
      special = SPEC_NAN_DEFAULT;
    end else if (cls_a == CLASS_INF || cls_b == CLASS_INF) begin
      special = SPEC_INF;
    end else if (cls_a == CLASS_ZERO || cls_b == CLASS_ZERO) begin
      special = SPEC_ZERO;
    end else begin
      special = SPEC_NONE;
    end
  end

  // valid is the only control state here
  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= in_valid;
    end
  end

  // payload, hidden bit prepended unless the operand is zero
  always_ff @(posedge clk) begin
    s1_sign    <= a[FP_WIDTH-1] ^ b[FP_WIDTH-1];
    s1_exp_a   <= a[FP_WIDTH-2 -: EXP_BITS];
    s1_exp_b   <= b[FP_WIDTH-2 -: EXP_BITS];
    s1_man_a   <= (cls_a == CLASS_ZERO) ? '0 : {1'b1, a[MAN_BITS-1:0]};
    s1_man_b   <= (cls_b == CLASS_ZERO) ? '0 : {1'b1, b[MAN_BITS-1:0]};
    s1_special <= special;
    // raw words kept for NaN pass-through in stage 4
    s1_nan_a   <= a;
    s1_nan_b   <= b;
  end

endmodule

`default_nettype wire

// File: src/fpmul_mant_mult.sv
`timescale 1ns/1ps
`default_nettype none

/* fpmul stage 2: 24x24 significand product and biased exponent sum */

module fpmul_mant_mult
  import fpmul_pkg::*;
(
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        s1_valid,
  input  wire                        s1_sign,
  input  wire [EXP_BITS-1:0]         s1_exp_a,
  input  wire [EXP_BITS-1:0]         s1_exp_b,
  input  wire [MAN_BITS:0]           s1_man_a,
  input  wire [MAN_BITS:0]           s1_man_b,
  input  wire special_t              s1_special,
  input  wire [FP_WIDTH-1:0]         s1_nan_a,
  input  wire [FP_WIDTH-1:0]         s1_nan_b,
  output logic                       s2_valid,
  output logic                       s2_sign,
  output logic signed [9:0]          s2_exp_sum,
  output logic [2*MAN_BITS+1:0]      s2_prod,
  output special_t                   s2_special,
  output logic [FP_WIDTH-1:0]        s2_nan_word
);

  logic signed [9:0] exp_sum;

  // e_a + e_b - bias, range -127..383 fits 10 bits signed
  assign exp_sum = $signed({2'b00, s1_exp_a}) + $signed({2'b00, s1_exp_b})
                   - 10'(EXP_BIAS);

  always_ff @(posedge clk) begin
    if (reset) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    s2_sign     <= s1_sign;
    s2_exp_sum  <= exp_sum;
    // unsigned product, 1.m x 1.m lands in [1, 4)
    s2_prod     <= s1_man_a * s1_man_b;
    s2_special  <= s1_special;
    // only one NaN word survives, don't care unless a NaN opcode
    s2_nan_word <= (s1_special == SPEC_NAN_B) ? s1_nan_b : s1_nan_a;
  end

endmodule

`default_nettype wire

// File: src/fpmul_normalize.sv
`timescale 1ns/1ps
`default_nettype none

/* fpmul stage 3: normalizes on the product MSB, truncates the mantissa
   and folds exponent underflow or overflow into the special code */

module fpmul_normalize
  import fpmul_pkg::*;
(
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        s2_valid,
  input  wire                        s2_sign,
  input  wire signed [9:0]           s2_exp_sum,
  input  wire [2*MAN_BITS+1:0]       s2_prod,
  input  wire special_t              s2_special,
  input  wire [FP_WIDTH-1:0]         s2_nan_word,
  output logic                       s3_valid,
  output logic                       s3_sign,
  output logic [EXP_BITS-1:0]        s3_exp,
  output logic [MAN_BITS-1:0]        s3_man,
  output special_t                   s3_special,
  output logic [FP_WIDTH-1:0]        s3_nan_word
);

  // ========================================
  // normalize
  // ========================================

  logic                    prod_msb;
  logic signed [9:0]       exp_adj;
  logic [MAN_BITS-1:0]     man_norm;
  special_t                special;

  // product in [2, 4) means one right shift
  assign prod_msb = s2_prod[2*MAN_BITS+1];

  // msb set: bit 47 becomes hidden, keep 46:24
  // msb clear: bit 46 is hidden, keep 45:23
  // low bits fall away, this is round toward zero
  assign man_norm = prod_msb ? s2_prod[2*MAN_BITS -: MAN_BITS]
                             : s2_prod[2*MAN_BITS-1 -: MAN_BITS];

  assign exp_adj = s2_exp_sum + $signed({9'd0, prod_msb});

  // ========================================
  // range check
  // ========================================

  // only a normal result can be rewritten here
  always_comb begin
    special = s2_special;
    if (s2_special == SPEC_NONE) begin
      if (exp_adj <= 10'sd0) begin
        // flush to signed zero, no denormal outputs
        special = SPEC_ZERO;
      end else if (exp_adj >= $signed({2'b00, EXP_ALL_ONES})) begin
        special = SPEC_INF;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s3_valid <= 1'b0;
    end else begin
      s3_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    s3_sign     <= s2_sign;
    // low 8 bits are valid whenever special stays SPEC_NONE
    s3_exp      <= exp_adj[EXP_BITS-1:0];
    s3_man      <= man_norm;
    s3_special  <= special;
    s3_nan_word <= s2_nan_word;
  end

endmodule

`default_nettype wire

// File: src/fpmul_pack.sv
`timescale 1ns/1ps
`default_nettype none

/* fpmul stage 4: builds the output word from the normal fields
   or from the special-result opcode */

module fpmul_pack
  import fpmul_pkg::*;
(
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        s3_valid,
  input  wire                        s3_sign,
  input  wire [EXP_BITS-1:0]         s3_exp,
  input  wire [MAN_BITS-1:0]         s3_man,
  input  wire special_t              s3_special,
  input  wire [FP_WIDTH-1:0]         s3_nan_word,
  output logic                       out_valid,
  output logic [FP_WIDTH-1:0]        product
);

  logic [FP_WIDTH-1:0] result;

  // opcode decode
  always_comb begin
    case (s3_special)
      SPEC_NONE: begin
        result = {s3_sign, s3_exp, s3_man};
      end
      SPEC_ZERO: begin
        // signed zero
        result = {s3_sign, {(FP_WIDTH-1){1'b0}}};
      end
      SPEC_INF: begin
        result = {s3_sign, EXP_ALL_ONES, {MAN_BITS{1'b0}}};
      end
      SPEC_NAN_A, SPEC_NAN_B: begin
        // NaN operand goes out bit for bit, payload and sign intact
        result = s3_nan_word;
      end
      SPEC_NAN_DEFAULT: begin
        result = DEFAULT_NAN;
      end
      default: begin
        // unused codes, treat as invalid operation
        result = DEFAULT_NAN;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= s3_valid;
    end
  end

  always_ff @(posedge clk) begin
    product <= result;
  end

endmodule

`default_nettype wire

// File: src/fpmul_top.sv
`timescale 1ns/1ps
`default_nettype none

/* fpmul top: four-stage pipelined single-precision multiplier,
   one operand pair per cycle, fixed latency of 4 */

module fpmul_top
  import fpmul_pkg::*;
(
  input  wire                    clk,
  input  wire                    reset,
  input  wire                    in_valid,
  input  wire [FP_WIDTH-1:0]     a,
  input  wire [FP_WIDTH-1:0]     b,
  output logic                   out_valid,
  output logic [FP_WIDTH-1:0]    product
);

  // ========================================
  // stage to stage wiring
  // ========================================

  // stage 1 outputs
  logic                   s1_valid, s1_sign;
  logic [EXP_BITS-1:0]    s1_exp_a, s1_exp_b;
  logic [MAN_BITS:0]      s1_man_a, s1_man_b;
  special_t               s1_special;
  logic [FP_WIDTH-1:0]    s1_nan_a, s1_nan_b;

  // stage 2 outputs
  logic                   s2_valid, s2_sign;
  logic signed [9:0]      s2_exp_sum;
  logic [2*MAN_BITS+1:0]  s2_prod;
  special_t               s2_special;
  logic [FP_WIDTH-1:0]    s2_nan_word;

  // stage 3 outputs
  logic                   s3_valid, s3_sign;
  logic [EXP_BITS-1:0]    s3_exp;
  logic [MAN_BITS-1:0]    s3_man;
  special_t               s3_special;
  logic [FP_WIDTH-1:0]    s3_nan_word;

  fpmul_unpack u_unpack (
    .clk, .reset, .in_valid, .a, .b,
    .s1_valid, .s1_sign, .s1_exp_a, .s1_exp_b,
    .s1_man_a, .s1_man_b, .s1_special, .s1_nan_a, .s1_nan_b
  );

  fpmul_mant_mult u_mant_mult (
    .clk, .reset,
    .s1_valid, .s1_sign, .s1_exp_a, .s1_exp_b,
    .s1_man_a, .s1_man_b, .s1_special, .s1_nan_a, .s1_nan_b,
    .s2_valid, .s2_sign, .s2_exp_sum, .s2_prod, .s2_special, .s2_nan_word
  );

  fpmul_normalize u_normalize (
    .clk, .reset,
    .s2_valid, .s2_sign, .s2_exp_sum, .s2_prod, .s2_special, .s2_nan_word,
    .s3_valid, .s3_sign, .s3_exp, .s3_man, .s3_special, .s3_nan_word
  );

  // last stage drives the top-level outputs
  fpmul_pack u_pack (
    .clk, .reset,
    .s3_valid, .s3_sign, .s3_exp, .s3_man, .s3_special, .s3_nan_word,
    .out_valid, .product
  );

endmodule

`default_nettype wire

// File: verification/fpmul_assert.sv
`timescale 1ns/1ps
`default_nettype none

/* fpmul protocol checks: valid latency and output encoding,
   bound onto the top level */

module fpmul_assert (
  input wire        clk,
  input wire        reset,
  input wire        in_valid,
  input wire        out_valid,
  input wire [31:0] product
);

  // number of failed assertions
  int fail_count = 0;

  // pipe is empty right after a reset cycle
  reset_clears: assert property (@(posedge clk) reset |=> !out_valid)
    else begin
      $error("out_valid high in the cycle after reset");
      fail_count++;
    end

  // every accepted input leaves four cycles later
  valid_latency: assert property (@(posedge clk) disable iff (reset)
                                  in_valid |-> ##4 out_valid)
    else begin
      $error("out_valid missing four cycles after in_valid");
      fail_count++;
    end

  // an idle input slot stays idle at the output
  idle_latency: assert property (@(posedge clk) disable iff (reset)
                                 !in_valid |-> ##4 !out_valid)
    else begin
      $error("out_valid high without a matching input");
      fail_count++;
    end

  // a valid output word is never unknown
  known_product: assert property (@(posedge clk) disable iff (reset)
                                  out_valid |-> !$isunknown(product))
    else begin
      $error("product has unknown bits while out_valid is high");
      fail_count++;
    end

endmodule

bind fpmul_top fpmul_assert u_assert (
  .clk       (clk),
  .reset     (reset),
  .in_valid  (in_valid),
  .out_valid (out_valid),
  .product   (product)
);

`default_nettype wire

// File: verification/fpmul_tb.sv
`timescale 1ns/1ps
`default_nettype none

/* fpmul testbench: directed and seeded random operands through the
   pipelined multiplier, scoreboarded against a behavioral model */

module fpmul_tb
  import fpmul_pkg::*;
();

  // ========================================
  // setup
  // ========================================

  localparam int DEPTH = 4;
  localparam int DIRECTED_OPS = 150;
  localparam int STREAM_OPS = 200;
  localparam int GAP_OPS = 60;
  localparam int RAND_OPS = 300;
  // gap ops add up to 2 idle cycles each
  // about 40 cycles for the reset test and DEPTH+2 for each of 6 drains
  localparam int CYCLE_LIMIT = DIRECTED_OPS + STREAM_OPS + 3*GAP_OPS + RAND_OPS
                               + 40 + 6*(DEPTH+2) + DEPTH + 100;

  logic        clk;
  logic        reset;
  logic        in_valid;
  logic [31:0] a;
  logic [31:0] b;
  wire         out_valid;
  wire  [31:0] product;

  logic [31:0]      expected_q[$];
  // in_valid history with bit DEPTH-1 as the slot due at the output now
  logic [DEPTH-1:0] valid_hist = '0;
  integer seed;
  int errors = 0;
  int checks = 0;
  int test_start_errors = 0;
  int tests_passed = 0;
  int tests_failed = 0;
  int cycles = 0;

  fpmul_top UUT (
    .clk, .reset, .in_valid, .a, .b, .out_valid, .product
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TB FAILED");
      $finish;
    end
  end

  // ========================================
  // reference model
  // ========================================

  // truncating multiply with denormals read as zero
  // out-of-range results flush to zero or saturate to infinity
  function automatic logic [31:0] model_mul(input logic [31:0] x, input logic [31:0] y);
    logic        sign;
    int          ex;
    int          ey;
    int          e;
    logic [63:0] sig;
    logic [31:0] res;
    sign = x[31] ^ y[31];
    ex = int'(x[30:23]);
    ey = int'(y[30:23]);
    if (ex == 255 && x[22:0] != 0) begin
      res = x;
    end else if (ey == 255 && y[22:0] != 0) begin
      res = y;
    end else if ((ex == 255 && ey == 0) || (ex == 0 && ey == 255)) begin
      res = DEFAULT_NAN;
    end else if (ex == 255 || ey == 255) begin
      res = {sign, 8'hFF, 23'd0};
    end else if (ex == 0 || ey == 0) begin
      res = {sign, 31'd0};
    end else begin
      sig = {40'd0, 1'b1, x[22:0]} * {40'd0, 1'b1, y[22:0]};
      e = ex + ey - EXP_BIAS;
      if (sig[47]) begin
        e = e + 1;
        sig = sig >> 24;
      end else begin
        sig = sig >> 23;
      end
      if (e <= 0) begin
        res = {sign, 31'd0};
      end else if (e >= 255) begin
        res = {sign, 8'hFF, 23'd0};
      end else begin
        res = {sign, e[7:0], sig[22:0]};
      end
    end
    return res;
  endfunction

  // operand biased toward zero, denormal, inf, NaN and range edges
  function automatic logic [31:0] rand_operand(input logic normal_only);
    logic [31:0] r;
    logic [31:0] m;
    logic [7:0]  exp;
    r = $random(seed);
    m = $random(seed);
    if (normal_only) begin
      exp = 8'd96 + {2'b00, r[9:4]};
    end else begin
      case (r[2:0])
        3'd0: exp = 8'd0;
        3'd1: exp = 8'hFF;
        3'd2, 3'd3: exp = 8'd191 + {2'b00, r[9:4]};
        3'd4: exp = 8'd1 + {2'b00, r[9:4]};
        default: exp = 8'd1 + (r[17:10] % 8'd254);
      endcase
      // half the all-ones exponents become infinity
      if (exp == 8'hFF && r[3]) begin
        m = '0;
      end
    end
    return {r[31], exp, m[22:0]};
  endfunction

  // ========================================
  // drive and check
  // ========================================

  task automatic check_outputs();
    logic [31:0] exp_word;
    assert (out_valid === valid_hist[DEPTH-1]) else begin
      $display("** Error at %0d ns: out_valid expected %b, got %b",
               $time, valid_hist[DEPTH-1], out_valid);
      errors++;
    end
    if (out_valid === 1'b1) begin
      assert (expected_q.size() > 0) else begin
        $display("out_valid high at %0d ns with no result expected", $time);
        errors++;
      end
      if (expected_q.size() > 0) begin
        exp_word = expected_q.pop_front();
        checks++;
        assert (product === exp_word) else begin
          $display("** Error at %0d ns: product expected %h, got %h",
                   $time, exp_word, product);
          errors++;
        end
      end
    end
  endtask

  // check the outputs of one cycle and then drive the next input slot
  task automatic step(input logic rst, input logic vld,
                      input logic [31:0] x, input logic [31:0] y);
    @(negedge clk);
    check_outputs();
    reset = rst;
    in_valid = vld;
    a = x;
    b = y;
    if (rst) begin
      // reset empties the pipe so the model drops in-flight items
      expected_q.delete();
      valid_hist = '0;
    end else begin
      valid_hist = {valid_hist[DEPTH-2:0], vld};
      if (vld) begin
        expected_q.push_back(model_mul(x, y));
      end
    end
  endtask

  task automatic op(input logic [31:0] x, input logic [31:0] y);
    step(1'b0, 1'b1, x, y);
  endtask

  task automatic idle(input int n);
    repeat (n) step(1'b0, 1'b0, '0, '0);
  endtask

  task automatic end_test(input string name);
    idle(DEPTH + 2);
    assert (expected_q.size() == 0) else begin
      $display("%0d expected results never left the pipe", expected_q.size());
      errors++;
      expected_q.delete();
    end
    if (errors == test_start_errors) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - test_start_errors);
    end
    test_start_errors = errors;
  endtask

  // ========================================
  // test sequence
  // ========================================

  initial begin
    logic [31:0] r;
    seed = 32'hcf0a_edae;
    reset = 1'b1;
    in_valid = 1'b0;
    a = '0;
    b = '0;
    repeat (3) @(posedge clk);

    // 1.5*2, 1.5*1.5 with shift, sign xor, truncation
    op(32'h3FC0_0000, 32'h4000_0000);
    op(32'h3FC0_0000, 32'h3FC0_0000);
    op(32'hC000_0000, 32'h4040_0000);
    op(32'hBF80_0000, 32'hBF80_0000);
    op(32'h3FFF_FFFF, 32'h3FFF_FFFF);
    repeat (20) op(rand_operand(1'b1), rand_operand(1'b1));
    end_test("normal");

    // NaN in both operands where A wins
    op(32'h7FC0_0001, 32'hFFA0_0002);
    op(32'h4000_0000, 32'h7F80_0001);
    op(32'hFFFF_FFFF, 32'h7F80_0000);
    op(32'h7F80_0000, 32'h0000_0000);
    op(32'h8000_0000, 32'hFF80_0000);
    op(32'h7F80_0000, 32'hC000_0000);
    // denormals count as zero
    op(32'h0000_0001, 32'h4040_0000);
    op(32'h807F_FFFF, 32'h4040_0000);
    op(32'h8000_0000, 32'h40A0_0000);
    end_test("special");

    op(32'h7F00_0000, 32'h7F00_0000);
    op(32'hFF00_0000, 32'h7F00_0000);
    op(32'h0080_0000, 32'h0080_0000);
    op(32'h8080_0000, 32'h0080_0000);
    op(32'h3F80_0000, 32'h0080_0000);
    op(32'h0080_0000, 32'h3F00_0000);
    op(32'h7F7F_FFFF, 32'h3F80_0000);
    op(32'h7F7F_FFFF, 32'h4000_0000);
    repeat (100) op(rand_operand(1'b0), rand_operand(1'b0));
    end_test("range");

    // full rate followed by random gaps of 0 to 2 idle cycles
    repeat (STREAM_OPS) op(rand_operand(1'b0), rand_operand(1'b0));
    repeat (GAP_OPS) begin
      op(rand_operand(1'b0), rand_operand(1'b0));
      r = $random(seed);
      idle(int'(r[1:0]) % 3);
    end
    end_test("throughput");

    // reset with the pipe full and the output going quiet
    repeat (10) op(rand_operand(1'b0), rand_operand(1'b0));
    repeat (3) step(1'b1, 1'b0, '0, '0);
    idle(6);
    repeat (10) op(rand_operand(1'b0), rand_operand(1'b0));
    end_test("mid_reset");

    // three in four slots valid
    repeat (RAND_OPS) begin
      r = $random(seed);
      step(1'b0, r[1:0] != 2'b00, rand_operand(1'b0), rand_operand(1'b0));
    end
    end_test("random");

    $display("tests passed %0d, failed %0d, product checks %0d",
             tests_passed, tests_failed, checks);
    if (errors == 0 && UUT.u_assert.fail_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
src/fpmul_pkg.sv
src/fpmul_unpack.sv
src/fpmul_mant_mult.sv
src/fpmul_normalize.sv
src/fpmul_pack.sv
src/fpmul_top.sv
verification/fpmul_assert.sv
verification/fpmul_tb.sv

// File: Makefile
# Verilator flow for the pipelined fp multiplier

TOP := fpmul_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP)

run: build
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

lint:
	verilator --lint-only -Wall --timing --assert -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir
